// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam logic [6:0]  opc_op      = 7'b0110011;
    localparam logic [6:0]  opc_op_imm  = 7'b0010011;
    localparam logic [6:0]  opc_lui     = 7'b0110111;
    localparam logic [6:0]  opc_load    = 7'b0000011;
    localparam logic [6:0]  opc_store   = 7'b0100011;
    localparam logic [6:0]  opc_branch  = 7'b1100011;
    localparam logic [6:0]  opc_jal     = 7'b1101111;
    localparam logic [6:0]  opc_jalr    = 7'b1100111;
    localparam logic [6:0]  opc_system  = 7'b1110011;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [3:0] {
        cls_alu_reg, cls_alu_imm, cls_lui, cls_load, cls_store,
        cls_branch, cls_jal, cls_jalr, cls_halt, cls_illegal
    } instr_class_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [2:0] {
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } branch_op_e;

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        branch_op_e   branch_op;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [31:0]  imm;
        logic         writes_rd;
    } decoded_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// ==== core/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic [31:0] next_pc,
    input  logic        next_valid,
    input  logic        halted,
    output wb_req_t     wb_req,
    input  wb_rsp_t     wb_rsp,
    output instr_u      instr,
    output logic [31:0] pc,
    output logic        instr_valid
);

    logic        started_q;
    logic        cyc_q;
    logic [31:0] pc_q;
    logic        instr_valid_q;
    instr_u      instr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started_q     <= 1'b0;
            cyc_q         <= 1'b0;
            pc_q          <= 32'd0;
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= cyc_q && wb_rsp.ack;
            if (run && !started_q && !halted) begin // First fetch once run is seen
                started_q <= 1'b1;
                cyc_q     <= 1'b1;
            end
            if (cyc_q && wb_rsp.ack)
                cyc_q <= 1'b0;
            if (next_valid) begin
                pc_q  <= next_pc;
                cyc_q <= !halted;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cyc_q && wb_rsp.ack)
            instr_q <= wb_rsp.dat; // Held until the next fetch completes
    end

    assign wb_req.cyc  = cyc_q;
    assign wb_req.stb  = cyc_q;
    assign wb_req.we   = 1'b0;
    assign wb_req.adr  = pc_q;
    assign wb_req.dat  = 32'd0;
    assign instr       = instr_q;
    assign pc          = pc_q;
    assign instr_valid = instr_valid_q;

endmodule

// ==== core/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder import rv_core_pkg::*; (
    input  instr_u   instr,
    output decoded_t dec
);

    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'd0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        dec           = '0;
        dec.cls       = cls_illegal; // Anything not matched below
        dec.alu_op    = alu_add;
        dec.branch_op = br_beq;
        dec.rd        = instr.r.rd;
        dec.rs1       = instr.r.rs1;
        dec.rs2       = instr.r.rs2;
        case (instr.r.opcode)
            opc_op: begin
                dec.cls = cls_alu_reg;
                case ({instr.r.funct7, instr.r.funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = alu_add;
                    {7'b0100000, 3'b000}: dec.alu_op = alu_sub;
                    {7'b0000000, 3'b111}: dec.alu_op = alu_and;
                    {7'b0000000, 3'b110}: dec.alu_op = alu_or;
                    {7'b0000000, 3'b100}: dec.alu_op = alu_xor;
                    {7'b0000000, 3'b010}: dec.alu_op = alu_slt;
                    {7'b0000000, 3'b011}: dec.alu_op = alu_sltu;
                    default:              dec.cls    = cls_illegal;
                endcase
            end
            opc_op_imm: if (instr.i.funct3 == 3'b000) begin // ADDI only
                dec.cls = cls_alu_imm;
                dec.imm = imm_i;
            end
            opc_lui: begin
                dec.cls = cls_lui;
                dec.imm = imm_u;
            end
            opc_load: if (instr.i.funct3 == 3'b010) begin
                dec.cls = cls_load;
                dec.imm = imm_i;
            end
            opc_store: if (instr.s.funct3 == 3'b010) begin
                dec.cls = cls_store;
                dec.imm = imm_s;
            end
            opc_branch: begin
                dec.cls = cls_branch;
                dec.imm = imm_b;
                case (instr.b.funct3)
                    3'b000:  dec.branch_op = br_beq;
                    3'b001:  dec.branch_op = br_bne;
                    3'b100:  dec.branch_op = br_blt;
                    3'b101:  dec.branch_op = br_bge;
                    3'b110:  dec.branch_op = br_bltu;
                    3'b111:  dec.branch_op = br_bgeu;
                    default: dec.cls       = cls_illegal;
                endcase
            end
            opc_jal: begin
                dec.cls = cls_jal;
                dec.imm = imm_j;
            end
            opc_jalr: if (instr.i.funct3 == 3'b000) begin
                dec.cls = cls_jalr;
                dec.imm = imm_i;
            end
            opc_system: if (instr == ebreak_word) dec.cls = cls_halt;
            default: dec.cls = cls_illegal;
        endcase
        dec.writes_rd = dec.cls inside {cls_alu_reg, cls_alu_imm, cls_lui,
                                        cls_load, cls_jal, cls_jalr};
    end

endmodule

// ==== core/jump_branch_unit.sv ====
`timescale 1ns/1ps

module jump_branch_unit import rv_core_pkg::*; (
    input  decoded_t    dec,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    output logic        taken,
    output logic [31:0] target
);

    logic        cond;
    logic [31:0] jalr_sum;

    always_comb begin
        case (dec.branch_op)
            br_beq:  cond = (rs1_val == rs2_val);
            br_bne:  cond = (rs1_val != rs2_val);
            br_blt:  cond = ($signed(rs1_val) < $signed(rs2_val));
            br_bge:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            br_bltu: cond = (rs1_val < rs2_val);
            br_bgeu: cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    assign taken = ((dec.cls == cls_branch) && cond) ||
                   (dec.cls == cls_jal) || (dec.cls == cls_jalr);

    assign jalr_sum = rs1_val + dec.imm;
    assign target   = (dec.cls == cls_jalr) ? {jalr_sum[31:1], 1'b0} // Bit 0 cleared
                                            : pc + dec.imm;

endmodule

// ==== core/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] pc,
    input  decoded_t    dec,
    input  logic        taken,
    input  logic [31:0] target,
    output logic [31:0] rs1_val,
    output logic [31:0] rs2_val,
    output wb_req_t     wb_req,
    input  wb_rsp_t     wb_rsp,
    output logic [31:0] next_pc,
    output logic        next_valid,
    output logic        halted
);

    typedef enum logic [1:0] {st_idle, st_mem, st_wb} state_e;

    state_e      state_q;
    logic [31:0] regs [1:31];
    logic [31:0] ld_data_q;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;
    logic [31:0] wb_data;

    assign rs1_val  = (dec.rs1 == 5'd0) ? 32'd0 : regs[dec.rs1];
    assign rs2_val  = (dec.rs2 == 5'd0) ? 32'd0 : regs[dec.rs2];
    assign op_b     = (dec.cls == cls_alu_reg) ? rs2_val : dec.imm;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_res = rs1_val + op_b;
            alu_sub:  alu_res = rs1_val - op_b;
            alu_and:  alu_res = rs1_val & op_b;
            alu_or:   alu_res = rs1_val | op_b;
            alu_xor:  alu_res = rs1_val ^ op_b;
            alu_slt:  alu_res = {31'd0, $signed(rs1_val) < $signed(op_b)};
            alu_sltu: alu_res = {31'd0, rs1_val < op_b};
            default:  alu_res = rs1_val + op_b;
        endcase
    end

    always_comb begin
        case (dec.cls)
            cls_lui:            wb_data = dec.imm;
            cls_load:           wb_data = ld_data_q;
            cls_jal, cls_jalr:  wb_data = pc_plus4; // Link value
            default:            wb_data = alu_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            halted  <= 1'b0;
        end else begin
            case (state_q)
                st_idle: if (instr_valid) begin // Decode and register read cycle
                    if (dec.cls == cls_halt || dec.cls == cls_illegal)
                        halted <= 1'b1;
                    else if (dec.cls == cls_load || dec.cls == cls_store)
                        state_q <= st_mem;
                    else
                        state_q <= st_wb;
                end
                st_mem: if (wb_rsp.ack) state_q <= st_wb;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_mem && wb_rsp.ack)
            ld_data_q <= wb_rsp.dat;
        if (state_q == st_wb && dec.writes_rd && dec.rd != 5'd0)
            regs[dec.rd] <= wb_data;
    end

    assign wb_req.cyc = (state_q == st_mem);
    assign wb_req.stb = (state_q == st_mem);
    assign wb_req.we  = (dec.cls == cls_store);
    assign wb_req.adr = rs1_val + dec.imm;
    assign wb_req.dat = rs2_val;

    assign next_pc    = taken ? target : pc_plus4;
    assign next_valid = (state_q == st_wb); // Ends the instruction

endmodule

// ==== hdl/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t host_req,
    input  wb_req_t data_req,
    input  wb_req_t fetch_req,
    output wb_rsp_t host_rsp,
    output wb_rsp_t data_rsp,
    output wb_rsp_t fetch_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    logic [2:0] cycs;     // Host, data, fetch
    logic [2:0] owner_q;
    logic [2:0] grant;
    logic       hold;

    assign cycs = {host_req.cyc, data_req.cyc, fetch_req.cyc};
    assign hold = |(owner_q & cycs);

    always_comb begin
        if (hold)
            grant = owner_q;
        else if (host_req.cyc)
            grant = 3'b100;
        else if (data_req.cyc)
            grant = 3'b010;
        else if (fetch_req.cyc)
            grant = 3'b001;
        else
            grant = 3'b000;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            owner_q <= 3'b000;
        else
            owner_q <= grant;
    end

    always_comb begin
        case (grant)
            3'b100:  mem_req = host_req;
            3'b010:  mem_req = data_req;
            3'b001:  mem_req = fetch_req;
            default: mem_req = '0;
        endcase
    end

    // Ack belongs to whoever held the bus on the previous edge
    assign host_rsp.ack  = mem_rsp.ack && owner_q[2];
    assign data_rsp.ack  = mem_rsp.ack && owner_q[1];
    assign fetch_rsp.ack = mem_rsp.ack && owner_q[0];
    assign host_rsp.dat  = owner_q[2] ? mem_rsp.dat : 32'd0;
    assign data_rsp.dat  = owner_q[1] ? mem_rsp.dat : 32'd0;
    assign fetch_rsp.dat = owner_q[0] ? mem_rsp.dat : 32'd0;

endmodule

// ==== hdl/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram import rv_core_pkg::*; #(
    parameter int MEM_ADDR_W = 10
) (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [31:0]           mem [0:(1 << MEM_ADDR_W) - 1];
    logic [MEM_ADDR_W-1:0] word_adr;
    logic                  ack_q;
    logic [31:0]           rd_q;
    logic                  hit;

    assign word_adr = req.adr[MEM_ADDR_W+1:2]; // Wraps modulo the depth
    assign hit      = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= hit; // Single beat, one cycle late
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rd_q <= mem[word_adr];
            if (req.we)
                mem[word_adr] <= req.dat;
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = rd_q;

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; #(
    parameter int MEM_ADDR_W = 10
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    run,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    output logic    halted
);

    instr_u      instr;
    logic [31:0] pc;
    logic        instr_valid;
    decoded_t    dec;
    logic        taken;
    logic [31:0] target;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] next_pc;
    logic        next_valid;
    wb_req_t     fetch_req, data_req, mem_req;
    wb_rsp_t     fetch_rsp, data_rsp, mem_rsp;

    fetch_unit fetch_unit_inst (
        .clk(clk), .rst_n(rst_n), .run(run),
        .next_pc(next_pc), .next_valid(next_valid), .halted(halted),
        .wb_req(fetch_req), .wb_rsp(fetch_rsp),
        .instr(instr), .pc(pc), .instr_valid(instr_valid)
    );

    instruction_decoder instruction_decoder_inst (.instr(instr), .dec(dec));

    jump_branch_unit jump_branch_unit_inst (
        .dec(dec), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .taken(taken), .target(target)
    );

    execute_unit execute_unit_inst (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .pc(pc),
        .dec(dec), .taken(taken), .target(target),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .wb_req(data_req), .wb_rsp(data_rsp),
        .next_pc(next_pc), .next_valid(next_valid), .halted(halted)
    );

    wb_arbiter wb_arbiter_inst (
        .clk(clk), .rst_n(rst_n),
        .host_req(host_req), .data_req(data_req), .fetch_req(fetch_req),
        .host_rsp(host_rsp), .data_rsp(data_rsp), .fetch_rsp(fetch_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    wb_ram #(.MEM_ADDR_W(MEM_ADDR_W)) wb_ram_inst (
        .clk(clk), .rst_n(rst_n), .req(mem_req), .rsp(mem_rsp)
    );

endmodule

// ==== sim/rv_core_asserts.sv ====
`timescale 1ns/1ps

module rv_core_asserts import rv_core_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input wb_req_t host_req,
    input wb_req_t data_req,
    input wb_req_t fetch_req,
    input wb_rsp_t host_rsp,
    input wb_rsp_t data_rsp,
    input wb_rsp_t fetch_rsp,
    input wb_req_t mem_req,
    input wb_rsp_t mem_rsp,
    input logic    halted
);

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.ack |-> mem_req.cyc && mem_req.stb)
        else $error("RAM ack outside an active bus cycle");

    host_stable: assert property (@(posedge clk) disable iff (!rst_n)
        host_req.cyc && !host_rsp.ack |=> $stable(host_req))
        else $error("Host request changed before ack");

    data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        data_req.cyc && !data_rsp.ack |=> $stable(data_req))
        else $error("Data request changed before ack");

    fetch_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req.cyc && !fetch_rsp.ack |=> $stable(fetch_req))
        else $error("Fetch request changed before ack");

    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && !fetch_req.cyc && !data_req.cyc)
        else $error("halted dropped without reset or the core still issued a request");

endmodule

// Top-level nets are the arbiter ports and the execute unit's halted output
bind rv_core_top rv_core_asserts rv_core_asserts_inst (
    .clk(clk), .rst_n(rst_n),
    .host_req(host_req), .data_req(data_req), .fetch_req(fetch_req),
    .host_rsp(host_rsp), .data_rsp(data_rsp), .fetch_rsp(fetch_rsp),
    .mem_req(mem_req), .mem_rsp(mem_rsp), .halted(halted)
);

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

    localparam int cycle_limit = 16 + 900 + 300 * 15 + 584; // Reset, host traffic, program
    localparam int data_words  = 48;

    logic        clk;
    logic        rst_n;
    logic        run;
    wb_req_t     host_req;
    wb_rsp_t     host_rsp;
    logic        halted;
    int          cycles = 0;
    logic [31:0] prog [$];
    logic [31:0] model_mem [0:1023];
    int          store_off;

    rv_core_top #(.MEM_ADDR_W(10)) rv_core_top_inst (
        .clk(clk), .rst_n(rst_n), .run(run),
        .host_req(host_req), .host_rsp(host_rsp), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the core did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // One host cycle, called and returning on a falling edge
    task automatic host_transfer(input logic we, input logic [31:0] adr,
                                 input logic [31:0] wdat, output logic [31:0] rdat);
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        do begin
            @(negedge clk);
        end while (!host_rsp.ack);
        rdat = host_rsp.dat;
        @(negedge clk); // Ack was seen, release next cycle
        host_req = '0;
        @(negedge clk);
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        host_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
        host_transfer(1'b0, adr, 32'd0, dat);
    endtask

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(int imm20, int rd);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic emit_store(input int rs2);
        emit(s_type(store_off, rs2, 1)); // Results follow the operands
        store_off += 4;
    endtask

    task automatic build_program();
        int rs_a [3]  = '{2, 4, 5};
        int rs_b [3]  = '{2, 5, 4};
        int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        int k;
        int p;
        int tgt;
        store_off = 16;
        emit(i_type(32'h400, 0, 0, 1, 7'h13));
        for (k = 0; k < 4; k++)
            emit(i_type(4 * k, 1, 2, 2 + k, 7'h03));
        emit(r_type(7'h00, 3, 2, 0, 6));
        emit_store(6);
        emit(r_type(7'h20, 2, 5, 0, 6)); // Small minus large
        emit_store(6);
        emit(r_type(7'h00, 4, 2, 7, 6));
        emit_store(6);
        emit(r_type(7'h00, 4, 3, 6, 6));
        emit_store(6);
        emit(r_type(7'h00, 3, 2, 4, 6));
        emit_store(6);
        emit(r_type(7'h00, 5, 4, 2, 6));
        emit_store(6);
        emit(r_type(7'h00, 5, 4, 3, 6));
        emit_store(6);
        emit(i_type(-5, 2, 0, 6, 7'h13));
        emit_store(6);
        emit(u_type(20'habcde, 6));
        emit_store(6);
        for (k = 0; k < 6; k++) begin
            for (p = 0; p < 3; p++) begin
                emit(i_type(100 + 3 * k + p, 0, 0, 7, 7'h13)); // Kept when taken
                emit(b_type(8, rs_b[p], rs_a[p], br_f3[k]));
                emit(i_type(-1, 0, 0, 7, 7'h13));
                emit_store(7);
            end
        end
        emit(j_type(8, 8));
        emit(i_type(-1, 0, 0, 8, 7'h13));
        emit_store(8);
        tgt = 4 * (prog.size() + 3);
        emit(i_type(tgt + 1, 0, 0, 10, 7'h13)); // Odd target
        emit(i_type(0, 10, 0, 11, 7'h67));
        emit(i_type(-1, 0, 0, 11, 7'h13));
        emit(j_type(4, 12)); // Link shows the pc it landed on
        emit_store(11);
        emit_store(12);
        emit(32'h0010_0073);
    endtask

    // Instruction-set model over model_mem
    function automatic void iss_run();
        logic [31:0] x [0:31];
        logic [31:0] pc, ins, a, b, imm_i, imm_s, imm_b, imm_j, res, next, ea;
        logic        wr;
        logic        t;
        int          k;
        for (k = 0; k < 32; k++)
            x[k] = 32'd0;
        pc = 32'd0;
        for (k = 0; k < 300; k++) begin
            ins   = model_mem[pc[11:2]];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            res   = 32'd0;
            wr    = 1'b1;
            next  = pc + 32'd4;
            case (ins[6:0])
                7'h33: case (ins[14:12])
                    3'd0:    res = ins[30] ? a - b : a + b;
                    3'd7:    res = a & b;
                    3'd6:    res = a | b;
                    3'd4:    res = a ^ b;
                    3'd2:    res = {31'd0, $signed(a) < $signed(b)};
                    default: res = {31'd0, a < b};
                endcase
                7'h13: res = a + imm_i;
                7'h37: res = {ins[31:12], 12'd0};
                7'h03: begin
                    ea  = a + imm_i;
                    res = model_mem[ea[11:2]];
                end
                7'h23: begin
                    ea = a + imm_s;
                    model_mem[ea[11:2]] = b;
                    wr = 1'b0;
                end
                7'h63: begin
                    case (ins[14:12])
                        3'd0:    t = (a == b);
                        3'd1:    t = (a != b);
                        3'd4:    t = ($signed(a) < $signed(b));
                        3'd5:    t = ($signed(a) >= $signed(b));
                        3'd6:    t = (a < b);
                        default: t = (a >= b);
                    endcase
                    if (t)
                        next = pc + imm_b;
                    wr = 1'b0;
                end
                7'h6f: begin
                    res  = pc + 32'd4;
                    next = pc + imm_j;
                end
                7'h67: begin
                    res  = pc + 32'd4;
                    next = (a + imm_i) & ~32'd1;
                end
                default: return; // EBREAK
            endcase
            if (wr && ins[11:7] != 5'd0)
                x[ins[11:7]] = res;
            pc = next;
        end
    endfunction

    initial begin
        logic [31:0] wr_val [0:3];
        logic [31:0] rd_val;
        logic [31:0] data_word;
        int          i;
        int          idx;
        void'($urandom(77394));
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("halted", {31'd0, halted}, 32'd0);

        for (i = 0; i < 4; i++) begin
            wr_val[i] = $urandom;
            wb_write(32'h600 + 4 * i, wr_val[i]);
        end
        for (i = 0; i < 4; i++) begin
            wb_read(32'h600 + 4 * i, rd_val);
            check($sformatf("host_rsp.dat @%h", 32'h600 + 4 * i), rd_val, wr_val[i]);
        end
        wr_val[0] = $urandom;
        wb_write(32'h1700, wr_val[0]); // Aliases 0x700 in a 1k-word RAM
        wb_read(32'h700, rd_val);
        check("host_rsp.dat @700", rd_val, wr_val[0]);

        build_program();
        for (i = 0; i < 1024; i++)
            model_mem[i] = 32'd0;
        for (i = 0; i < prog.size(); i++) begin
            model_mem[i] = prog[i];
            wb_write(4 * i, prog[i]);
        end
        for (i = 0; i < data_words; i++) begin
            data_word = $urandom;
            if (i == 0)
                data_word = (data_word & 32'h7fff_ffff) | 32'h0000_1000;
            if (i == 2)
                data_word = data_word | 32'h8000_0000; // Negative, and large unsigned
            if (i == 3)
                data_word = data_word & 32'h0000_00ff;
            model_mem[256 + i] = data_word;
            wb_write(32'h400 + 4 * i, data_word);
        end
        iss_run();

        run = 1'b1;
        for (i = 0; i < 8; i++) begin
            idx = $urandom_range(0, prog.size() - 1);
            wb_read(4 * idx, rd_val);
            check($sformatf("program word @%h", 4 * idx), rd_val, prog[idx]);
        end
        while (!halted)
            @(negedge clk);

        for (i = 0; i < data_words; i++) begin
            wb_read(32'h400 + 4 * i, rd_val);
            check($sformatf("data word @%h", 32'h400 + 4 * i), rd_val, model_mem[256 + i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
common/rv_core_pkg.sv
core/fetch_unit.sv
core/instruction_decoder.sv
core/jump_branch_unit.sv
core/execute_unit.sv
hdl/wb_arbiter.sv
hdl/wb_ram.sv
hdl/rv_core_top.sv
sim/rv_core_asserts.sv
sim/rv_core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim
	./obj_dir/rv_core_sim | tee /dev/stderr | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
